// ==== exu_config.svh ====
// Build-time configuration of the ALU execution unit
// W-form operations assume EXU_XLEN is 64; narrower widths are not supported
// EXU_IQ_DEPTH must be at least 1; non power-of-two depths are allowed
// EXU_SKIP_REG set to 1 removes the output register entirely

`ifndef EXU_CONFIG_SVH_
`define EXU_CONFIG_SVH_

// Operand and result width
`define EXU_XLEN 64

// Width of the ROB tag attached to each instruction
`define EXU_ROB_IDX_LEN 4

// Width of the ALU operation code
`define EXU_CTL_LEN 4

// Issue queue entries
`define EXU_IQ_DEPTH 4

// 1 bypasses the output spill cell (purely combinational ALU)
`define EXU_SKIP_REG 0

`endif

// ==== exu_pkg.sv ====
// Shared types and ALU operation codes of the execution unit
// Widths come from exu_config.svh
// Code 15 is reserved; the ALU flags it as an illegal instruction

`include "exu_config.svh"

package exu_pkg;

  // --------------------------------------------------------------------
  // Vector types
  // --------------------------------------------------------------------

  // One operand or result word
  typedef logic [`EXU_XLEN-1:0] xlen_t;

  // ROB tag of an instruction
  typedef logic [`EXU_ROB_IDX_LEN-1:0] rob_idx_t;

  // ALU operation code
  typedef logic [`EXU_CTL_LEN-1:0] alu_ctl_t;

  // --------------------------------------------------------------------
  // ALU control codes
  // --------------------------------------------------------------------

  // Add and subtract, full and word forms
  localparam alu_ctl_t ALU_ADD  = alu_ctl_t'(0);
  localparam alu_ctl_t ALU_ADDW = alu_ctl_t'(1);
  localparam alu_ctl_t ALU_SUB  = alu_ctl_t'(2);
  localparam alu_ctl_t ALU_SUBW = alu_ctl_t'(3);

  // Bitwise logic
  localparam alu_ctl_t ALU_AND  = alu_ctl_t'(4);
  localparam alu_ctl_t ALU_OR   = alu_ctl_t'(5);
  localparam alu_ctl_t ALU_XOR  = alu_ctl_t'(6);

  // Shifts, full and word forms
  localparam alu_ctl_t ALU_SLL  = alu_ctl_t'(7);
  localparam alu_ctl_t ALU_SLLW = alu_ctl_t'(8);
  localparam alu_ctl_t ALU_SRL  = alu_ctl_t'(9);
  localparam alu_ctl_t ALU_SRLW = alu_ctl_t'(10);
  localparam alu_ctl_t ALU_SRA  = alu_ctl_t'(11);
  localparam alu_ctl_t ALU_SRAW = alu_ctl_t'(12);

  // Set-less-than, result is 1 or 0
  localparam alu_ctl_t ALU_SLT  = alu_ctl_t'(13);
  localparam alu_ctl_t ALU_SLTU = alu_ctl_t'(14);

  // Reserved, always raises the exception flag
  localparam alu_ctl_t ALU_ILL  = alu_ctl_t'(15);

endpackage

// ==== exu_issue_if.sv ====
// Issue bundle between the issue queue and the ALU
// Transfer on a rising clock edge with valid and ready both high
// Payload must stay stable while valid is high and ready is low

interface exu_issue_if import exu_pkg::*; ();

  // Handshake
  logic     valid;
  logic     ready;

  // Instruction payload
  alu_ctl_t ctl;
  rob_idx_t rob_idx;
  xlen_t    rs1;
  xlen_t    rs2;

  // Queue side, drives the instruction
  modport src (
    output valid,
    output ctl,
    output rob_idx,
    output rs1,
    output rs2,
    input  ready
  );

  // ALU side, accepts the instruction
  modport dst (
    input  valid,
    input  ctl,
    input  rob_idx,
    input  rs1,
    input  rs2,
    output ready
  );

endinterface

// ==== spill_cell_flush.sv ====
// Two-entry skid buffer with flush and a registered ready
// With SKIP set the cell is a plain wire and has no storage
// Holds at most two items; ready_o falls once the spare slot is taken

module spill_cell_flush #(
  parameter type DATA_T = logic,
  parameter bit  SKIP   = 1'b0
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  flush_i,

  // Handshake
  input  logic  valid_i,
  input  logic  ready_i,
  output logic  valid_o,
  output logic  ready_o,

  // Payload
  input  DATA_T data_i,
  output DATA_T data_o
);

  generate
    if (SKIP) begin : gen_skip
      // Straight through, no cycle added
      assign valid_o = valid_i;
      assign ready_o = ready_i;
      assign data_o  = data_i;
    end else begin : gen_reg
      logic  main_valid;
      logic  spare_valid;
      DATA_T main_data;
      DATA_T spare_data;
      logic  in_fire;
      logic  out_fire;
      logic  main_free;

      // Spare slot empty means one more item fits
      assign ready_o   = ~spare_valid;
      assign valid_o   = main_valid;
      assign data_o    = main_data;

      assign in_fire   = valid_i & ready_o;
      assign out_fire  = main_valid & ready_i;
      // Main slot can take new data this cycle
      assign main_free = ~main_valid | out_fire;

      // ----------------------------------------------------------------
      // Occupancy
      // ----------------------------------------------------------------

      always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
          main_valid  <= 1'b0;
          spare_valid <= 1'b0;
        end else if (flush_i) begin
          main_valid  <= 1'b0;
          spare_valid <= 1'b0;
        end else if (main_free) begin
          // Spare drains first to keep order
          main_valid  <= spare_valid | in_fire;
          spare_valid <= 1'b0;
        end else if (in_fire) begin
          // Main stalled, park the input
          spare_valid <= 1'b1;
        end
      end

      // ----------------------------------------------------------------
      // Payload
      // ----------------------------------------------------------------

      always_ff @(posedge clk_i) begin
        if (main_free) begin
          main_data <= spare_valid ? spare_data : data_i;
        end
        if (in_fire && !main_free) begin
          spare_data <= data_i;
        end
      end
    end
  endgenerate

endmodule

// ==== issue_queue.sv ====
// In-order issue queue, depth set by EXU_IQ_DEPTH
// A push in the same cycle as flush_i is dropped with the rest
// When full, a push is still accepted if the head leaves in that cycle

`include "exu_config.svh"

module issue_queue import exu_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,

  // Upstream issue port
  input  logic     valid_i,
  input  alu_ctl_t ctl_i,
  input  rob_idx_t rob_idx_i,
  input  xlen_t    rs1_i,
  input  xlen_t    rs2_i,
  output logic     ready_o,

  // Head of queue toward the ALU
  exu_issue_if.src iss
);

  localparam int unsigned DEPTH = `EXU_IQ_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  // One stored instruction
  typedef struct packed {
    alu_ctl_t ctl;
    rob_idx_t rob_idx;
    xlen_t    rs1;
    xlen_t    rs2;
  } iq_entry_t;

  iq_entry_t mem [DEPTH];
  iq_entry_t wr_entry;
  ptr_t      wr_ptr;
  ptr_t      rd_ptr;
  cnt_t      count;
  logic      full;
  logic      push;
  logic      pop;

  // --------------------------------------------------------------------
  // Handshake
  // --------------------------------------------------------------------

  assign full    = (count == cnt_t'(DEPTH));
  // Full queue still takes a new entry while the head drains
  assign ready_o = ~full | iss.ready;
  assign push    = valid_i & ready_o;
  assign pop     = iss.valid & iss.ready;

  // --------------------------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush_i) begin
      // Drop everything in flight
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count unchanged
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // --------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------

  assign wr_entry.ctl     = ctl_i;
  assign wr_entry.rob_idx = rob_idx_i;
  assign wr_entry.rs1     = rs1_i;
  assign wr_entry.rs2     = rs2_i;

  // Payload only, no reset
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= wr_entry;
    end
  end

  // Head entry, visible the cycle after its write
  assign iss.valid   = (count != '0);
  assign iss.ctl     = mem[rd_ptr].ctl;
  assign iss.rob_idx = mem[rd_ptr].rob_idx;
  assign iss.rs1     = mem[rd_ptr].rs1;
  assign iss.rs2     = mem[rd_ptr].rs2;

endmodule

// ==== alu.sv ====
// RV64 integer ALU with a spill cell on its output
// W forms operate on the low 32 bits and sign-extend bit 31
// Unknown codes give a zero result and raise the exception flag
// The flag is read by the ROB as an illegal instruction

`include "exu_config.svh"

module alu import exu_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,

  // Instruction from the issue queue
  exu_issue_if.dst iss,

  // Result toward the CDB
  input  logic     ready_i,
  output logic     valid_o,
  output rob_idx_t rob_idx_o,
  output xlen_t    result_o,
  output logic     except_raised_o
);

  // Full shift amount width, 6 bits for RV64
  localparam int unsigned SHAMT_W = $clog2(`EXU_XLEN);

  // Word form result, sign-extended to XLEN
  function automatic xlen_t sext_w(input logic [31:0] w);
    return {{(`EXU_XLEN - 32){w[31]}}, w};
  endfunction

  // Payload carried by the output register
  typedef struct packed {
    xlen_t    res;
    rob_idx_t rob_idx;
    logic     except_raised;
  } out_reg_data_t;

  logic [SHAMT_W-1:0] shamt;
  logic [4:0]         shamt_w;
  logic [31:0]        addw_res;
  logic [31:0]        subw_res;
  logic [31:0]        sllw_res;
  logic [31:0]        srlw_res;
  logic [31:0]        sraw_res;
  logic               lt_s;
  logic               lt_u;
  xlen_t              result;
  logic               except_raised;
  out_reg_data_t      out_reg_data_in;
  out_reg_data_t      out_reg_data_out;

  // --------------------------------------------------------------------
  // Datapath helpers
  // --------------------------------------------------------------------

  // W forms only look at 5 bits of rs2
  assign shamt    = iss.rs2[SHAMT_W-1:0];
  assign shamt_w  = iss.rs2[4:0];

  assign addw_res = iss.rs1[31:0] + iss.rs2[31:0];
  assign subw_res = iss.rs1[31:0] - iss.rs2[31:0];
  assign sllw_res = iss.rs1[31:0] << shamt_w;
  assign srlw_res = iss.rs1[31:0] >> shamt_w;
  // Arithmetic shift of the low word
  assign sraw_res = $signed(iss.rs1[31:0]) >>> shamt_w;

  // True comparisons
  assign lt_s     = $signed(iss.rs1) < $signed(iss.rs2);
  assign lt_u     = iss.rs1 < iss.rs2;

  // --------------------------------------------------------------------
  // Operation select
  // --------------------------------------------------------------------

  always_comb begin
    result        = '0;
    except_raised = 1'b0;
    case (iss.ctl)
      ALU_ADD:  result = iss.rs1 + iss.rs2;
      ALU_ADDW: result = sext_w(addw_res);
      ALU_SUB:  result = iss.rs1 - iss.rs2;
      ALU_SUBW: result = sext_w(subw_res);
      ALU_AND:  result = iss.rs1 & iss.rs2;
      ALU_OR:   result = iss.rs1 | iss.rs2;
      ALU_XOR:  result = iss.rs1 ^ iss.rs2;
      ALU_SLL:  result = iss.rs1 << shamt;
      ALU_SLLW: result = sext_w(sllw_res);
      ALU_SRL:  result = iss.rs1 >> shamt;
      ALU_SRLW: result = sext_w(srlw_res);
      ALU_SRA:  result = $signed(iss.rs1) >>> shamt;
      ALU_SRAW: result = sext_w(sraw_res);
      ALU_SLT:  result = {{(`EXU_XLEN - 1){1'b0}}, lt_s};
      ALU_SLTU: result = {{(`EXU_XLEN - 1){1'b0}}, lt_u};
      // ALU_ILL and anything unknown
      default:  except_raised = 1'b1;
    endcase
  end

  // --------------------------------------------------------------------
  // Output register
  // --------------------------------------------------------------------

  assign out_reg_data_in.res           = result;
  assign out_reg_data_in.rob_idx       = iss.rob_idx;
  assign out_reg_data_in.except_raised = except_raised;

  assign result_o        = out_reg_data_out.res;
  assign rob_idx_o       = out_reg_data_out.rob_idx;
  assign except_raised_o = out_reg_data_out.except_raised;

  // Ready toward the queue is the spill cell's registered ready
  spill_cell_flush #(
    .DATA_T (out_reg_data_t),
    .SKIP   (`EXU_SKIP_REG)
  ) u_out_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (iss.valid),
    .ready_i (ready_i),
    .valid_o (valid_o),
    .ready_o (iss.ready),
    .data_i  (out_reg_data_in),
    .data_o  (out_reg_data_out)
  );

endmodule

// ==== alu_exu_top.sv ====
// ALU execution unit, issue queue followed by the ALU
// Results leave in issue order, tagged with the ROB index
// flush_i drops every item held in the queue and the output register

module alu_exu_top import exu_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,

  // Issue port
  input  logic     issue_valid_i,
  output logic     issue_ready_o,
  input  alu_ctl_t ctl_i,
  input  rob_idx_t rob_idx_i,
  input  xlen_t    rs1_i,
  input  xlen_t    rs2_i,

  // Common data bus port
  output logic     cdb_valid_o,
  input  logic     cdb_ready_i,
  output rob_idx_t rob_idx_o,
  output xlen_t    result_o,
  output logic     except_raised_o
);

  // Queue head to ALU
  exu_issue_if u_iss_if ();

  issue_queue u_iq (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .flush_i   (flush_i),
    .valid_i   (issue_valid_i),
    .ctl_i     (ctl_i),
    .rob_idx_i (rob_idx_i),
    .rs1_i     (rs1_i),
    .rs2_i     (rs2_i),
    .ready_o   (issue_ready_o),
    .iss       (u_iss_if.src)
  );

  alu u_alu (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .flush_i         (flush_i),
    .iss             (u_iss_if.dst),
    .ready_i         (cdb_ready_i),
    .valid_o         (cdb_valid_o),
    .rob_idx_o       (rob_idx_o),
    .result_o        (result_o),
    .except_raised_o (except_raised_o)
  );

endmodule

// ==== tb_alu_exu.sv ====
// Self-checking testbench of the ALU execution unit
// Reference model assumes EXU_XLEN of 64, as the W forms do
// Checking is done by concurrent assertions on every CDB transfer
// Simulator must support concurrent assertions and $sampled

`include "exu_config.svh"

module tb_alu_exu import exu_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // Items per test, sized so the run limit follows the test length
  localparam int N_RAND64    = 3;
  localparam int N_RANDW     = 4;
  localparam int N_ILL       = 3;
  localparam int N_BP        = 24;
  localparam int N_CAP       = `EXU_IQ_DEPTH + 2;
  localparam int N_ITEMS     = 10 * N_RAND64 + 10 + 5 * N_RANDW + 3 + N_ILL + N_BP + N_CAP + 7;
  localparam int CYCLE_LIMIT = 20 * N_ITEMS + 200;
  localparam xlen_t MIN64    = 64'h8000_0000_0000_0000;

  // One expected CDB beat
  typedef struct packed {
    xlen_t    res;
    rob_idx_t tag;
    logic     exc;
  } exp_t;

  logic     clk_i = 1'b0;
  logic     rst_n_i;
  logic     flush_i;
  logic     issue_valid_i;
  logic     issue_ready_o;
  alu_ctl_t ctl_i;
  rob_idx_t rob_idx_i;
  xlen_t    rs1_i;
  xlen_t    rs2_i;
  logic     cdb_valid_o;
  logic     cdb_ready_i;
  rob_idx_t rob_idx_o;
  xlen_t    result_o;
  logic     except_raised_o;

  integer   seed       = 61780;
  int       err_cnt    = 0;
  int       iss_cnt    = 0;
  int       out_cnt    = 0;
  int       flush_cnt  = 0;
  int       cyc_cnt    = 0;
  int       ready_mode = 0;    // 0 high, 1 low, 2 random
  int       accepted;
  rob_idx_t next_tag   = '0;
  exp_t     exp_q[$];
  exp_t     exp_head;
  logic     exp_valid  = 1'b0;
  logic [2**$bits(rob_idx_t)-1:0] flushed_mask = '0;
  alu_ctl_t ops64 [10] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                           ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU};
  alu_ctl_t opsw  [5]  = '{ALU_ADDW, ALU_SUBW, ALU_SLLW, ALU_SRLW, ALU_SRAW};

  alu_exu_top u_dut (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .flush_i         (flush_i),
    .issue_valid_i   (issue_valid_i),
    .issue_ready_o   (issue_ready_o),
    .ctl_i           (ctl_i),
    .rob_idx_i       (rob_idx_i),
    .rs1_i           (rs1_i),
    .rs2_i           (rs2_i),
    .cdb_valid_o     (cdb_valid_o),
    .cdb_ready_i     (cdb_ready_i),
    .rob_idx_o       (rob_idx_o),
    .result_o        (result_o),
    .except_raised_o (except_raised_o)
  );

  // 40 ns period
  always #20 clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // Reference model, written from the RV64 operation rules
  // ----------------------------------------------------------------------

  function automatic exp_t model_op(input alu_ctl_t ctl, input xlen_t a, input xlen_t b,
                                    input rob_idx_t tag);
    exp_t        e;
    logic [31:0] w;
    int          sh;
    int          shw;
    sh    = b[5:0];
    shw   = b[4:0];
    w     = '0;
    e.res = '0;
    e.tag = tag;
    e.exc = 1'b0;
    case (ctl)
      ALU_ADD:  e.res = a + b;
      // Two's complement subtract
      ALU_SUB:  e.res = a + ~b + 64'd1;
      ALU_AND:  e.res = a & b;
      ALU_OR:   e.res = a | b;
      ALU_XOR:  e.res = a ^ b;
      ALU_SLL:  e.res = a << sh;
      ALU_SRL:  e.res = a >> sh;
      // Logical shift with the vacated bits refilled by the sign
      ALU_SRA:  e.res = (a >> sh) | (a[63] ? ~({64{1'b1}} >> sh) : 64'd0);
      // Different signs decide at once, equal signs order as unsigned
      ALU_SLT:  e.res = xlen_t'((a[63] != b[63]) ? a[63] : (a < b));
      ALU_SLTU: e.res = xlen_t'(a < b);
      ALU_ADDW: w = a[31:0] + b[31:0];
      ALU_SUBW: w = a[31:0] + ~b[31:0] + 32'd1;
      ALU_SLLW: w = a[31:0] << shw;
      ALU_SRLW: w = a[31:0] >> shw;
      ALU_SRAW: w = (a[31:0] >> shw) | (a[31] ? ~(32'hffff_ffff >> shw) : 32'd0);
      default:  e.exc = 1'b1;
    endcase
    // Word results carry bit 31 into the upper half
    if (ctl inside {ALU_ADDW, ALU_SUBW, ALU_SLLW, ALU_SRLW, ALU_SRAW}) begin
      e.res = {{32{w[31]}}, w};
    end
    return e;
  endfunction

  function automatic xlen_t rand64();
    return {$random(seed), $random(seed)};
  endfunction

  // Scoreboard, updated with pre-edge values like the DUT flops
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      exp_q.delete();
    end else if (flush_i) begin
      // Tags in flight must never show up
      foreach (exp_q[i])
        flushed_mask[exp_q[i].tag] = 1'b1;
      flush_cnt = flush_cnt + exp_q.size();
      exp_q.delete();
    end else begin
      if (cdb_valid_o && cdb_ready_i) begin
        if (exp_q.size() > 0)
          void'(exp_q.pop_front());
        out_cnt = out_cnt + 1;
      end
      if (issue_valid_i && issue_ready_o) begin
        exp_q.push_back(model_op(ctl_i, rs1_i, rs2_i, rob_idx_i));
        flushed_mask[rob_idx_i] = 1'b0;
        iss_cnt = iss_cnt + 1;
      end
    end
    exp_valid = (exp_q.size() > 0);
    if (exp_valid)
      exp_head = exp_q[0];
  end

  // Run limit
  always @(posedge clk_i) begin
    cyc_cnt = cyc_cnt + 1;
    if (cyc_cnt >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, DUT stopped draining results", cyc_cnt);
      $display("Test failed");
      $finish;
    end
  end

  // CDB ready driver
  always @(negedge clk_i) begin
    if (ready_mode == 1)
      cdb_ready_i = 1'b0;
    else if (ready_mode == 2)
      cdb_ready_i = $random(seed) & 1;
    else
      cdb_ready_i = 1'b1;
  end

  // ----------------------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------------------

  // Result, tag and flag of the oldest expected item
  a_cdb_match: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cdb_valid_o && cdb_ready_i) |-> (exp_valid && rob_idx_o == exp_head.tag &&
      result_o == exp_head.res && except_raised_o == exp_head.exc))
    else begin
      err_cnt++;
      $display("[FAIL] %0t cdb tag=%0d res=%h exc=%b, expected tag=%0d res=%h exc=%b",
               $time, $sampled(rob_idx_o), $sampled(result_o), $sampled(except_raised_o),
               $sampled(exp_head.tag), $sampled(exp_head.res), $sampled(exp_head.exc));
    end

  // Stalled output holds
  a_cdb_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cdb_valid_o && !cdb_ready_i && !flush_i) |=> (cdb_valid_o && $stable(result_o) &&
      $stable(rob_idx_o) && $stable(except_raised_o)))
    else begin
      err_cnt++;
      $display("[FAIL] %0t cdb output changed while stalled", $time);
    end

  a_ill_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cdb_valid_o && except_raised_o) |-> (result_o == '0))
    else begin
      err_cnt++;
      $display("[FAIL] %0t nonzero result %h with exception", $time, $sampled(result_o));
    end

  // Unit empty and open right after a flush
  a_flush_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> (!cdb_valid_o && issue_ready_o))
    else begin
      err_cnt++;
      $display("[FAIL] %0t unit not empty after flush", $time);
    end

  a_no_flushed_tag: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cdb_valid_o && cdb_ready_i) |-> !flushed_mask[rob_idx_o])
    else begin
      err_cnt++;
      $display("[FAIL] %0t flushed tag %0d reached the CDB", $time, $sampled(rob_idx_o));
    end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic issue(input alu_ctl_t ctl, input xlen_t a, input xlen_t b);
    issue_valid_i = 1'b1;
    ctl_i         = ctl;
    rob_idx_i     = next_tag;
    rs1_i         = a;
    rs2_i         = b;
    // Ready only moves on a rising edge
    while (!issue_ready_o)
      @(negedge clk_i);
    @(negedge clk_i);
    issue_valid_i = 1'b0;
    next_tag      = next_tag + 1'b1;
  endtask

  task automatic drain_and_report(input string name);
    while (exp_valid)
      @(negedge clk_i);
    repeat (2) @(negedge clk_i);
    $display("%-9s done: issued=%0d completed=%0d errors=%0d", name, iss_cnt, out_cnt,
             err_cnt);
  endtask

  initial begin
    rst_n_i       = 1'b0;
    flush_i       = 1'b0;
    issue_valid_i = 1'b0;
    ctl_i         = ALU_ADD;
    rob_idx_i     = '0;
    rs1_i         = '0;
    rs2_i         = '0;
    cdb_ready_i   = 1'b1;
    repeat (16) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);

    // 64-bit ops, random then shift and compare edges
    foreach (ops64[k])
      for (int i = 0; i < N_RAND64; i++)
        issue(ops64[k], rand64(), rand64());
    issue(ALU_SLL, rand64(), 64'd0);
    issue(ALU_SLL, rand64(), 64'd63);
    issue(ALU_SRL, rand64(), 64'd0);
    issue(ALU_SRL, rand64(), 64'd63);
    issue(ALU_SRA, rand64(), 64'd0);
    issue(ALU_SRA, MIN64, 64'd63);
    issue(ALU_SLT, MIN64, 64'd1);
    issue(ALU_SLT, 64'd1, MIN64);
    issue(ALU_SLTU, MIN64, 64'd1);
    issue(ALU_SLTU, 64'd1, MIN64);
    drain_and_report("ops64");

    // W forms, bit 5 of the shift amount must be ignored
    foreach (opsw[k])
      for (int i = 0; i < N_RANDW; i++)
        issue(opsw[k], rand64(), rand64());
    issue(ALU_ADDW, 64'h0000_0000_7fff_ffff, 64'd1);
    issue(ALU_SLLW, 64'd1, 64'd63);
    issue(ALU_SRAW, 64'h0000_0000_8000_0000, 64'd33);
    drain_and_report("opsw");

    for (int i = 0; i < N_ILL; i++)
      issue(ALU_ILL, rand64(), rand64());
    drain_and_report("illegal");

    // Random ops and codes under random back-pressure
    ready_mode = 2;
    for (int i = 0; i < N_BP; i++)
      issue(alu_ctl_t'($random(seed)), rand64(), rand64());
    ready_mode = 0;
    drain_and_report("backpres");

    // Blocked CDB, count accepted issues until ready falls
    ready_mode = 1;
    repeat (2) @(negedge clk_i);
    accepted = 0;
    while (issue_ready_o && accepted < N_CAP + 2) begin
      issue(ALU_XOR, rand64(), rand64());
      accepted++;
    end
    repeat (3) @(negedge clk_i);
    assert (accepted == N_CAP && !issue_ready_o)
      else begin
        err_cnt++;
        $display("[FAIL] %0t accepted %0d issues with CDB blocked, expected %0d", $time,
                 accepted, N_CAP);
      end
    ready_mode = 0;
    drain_and_report("capacity");

    // Flush with four items in flight, then fresh issues
    ready_mode = 1;
    repeat (2) @(negedge clk_i);
    next_tag = rob_idx_t'(0);
    repeat (4) issue(ALU_ADD, rand64(), rand64());
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i    = 1'b0;
    ready_mode = 0;
    next_tag   = rob_idx_t'(8);
    repeat (3) issue(ALU_SUB, rand64(), rand64());
    drain_and_report("flush");

    assert (out_cnt == iss_cnt - flush_cnt)
      else begin
        err_cnt++;
        $display("[FAIL] %0t completed %0d of %0d unflushed issues", $time, out_cnt,
                 iss_cnt - flush_cnt);
      end
    $display("Summary: issued=%0d completed=%0d flushed=%0d errors=%0d", iss_cnt, out_cnt,
             flush_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+.
exu_pkg.sv
exu_issue_if.sv
spill_cell_flush.sv
issue_queue.sv
alu.sv
alu_exu_top.sv
tb_alu_exu.sv

// ==== Bender.yml ====
package:
  name: alu_exu

sources:
  - include_dirs:
      - .
    files:
      - exu_pkg.sv
      - exu_issue_if.sv
      - spill_cell_flush.sv
      - issue_queue.sv
      - alu.sv
      - alu_exu_top.sv

  - target: test
    include_dirs:
      - .
    files:
      - tb_alu_exu.sv
